//--- hdl/uart_line_pkg.sv
`default_nettype none

// line-level view of the link: character size, parity mode and the
// per-bit timing configuration that both directions share
package uart_line_pkg;

    localparam int data_width = 8;                  // data bits per character, sent lsb first
    localparam int bit_idx_width = $clog2(data_width); // wide enough to index a data bit

    // the prescale field counts clock cycles per bit divided by 8
    localparam int prescale_width = 16;

    // a bit period counter has to hold prescale times 8
    localparam int bit_time_width = prescale_width + 3;

    // parity bit after data bit 7, or no parity bit at all
    typedef enum logic [1:0] {
        parity_none = 2'd0,
        parity_even = 2'd1,  // parity bit makes the count of ones even
        parity_odd  = 2'd2   // parity bit makes the count of ones odd
    } parity_t;

    // configuration that arrives on plain input ports, held stable while busy
    typedef struct packed {
        logic [prescale_width-1:0] prescale;
        parity_t                   parity;
    } line_cfg_t;

endpackage

`default_nettype wire

//--- hdl/uart_stream_pkg.sv
`default_nettype none

// stream-level view of the link: what the receiver hands to the fabric,
// how deep the receive buffer is and the state sets of both directions
package uart_stream_pkg;

    // one received character together with its line error flags
    typedef struct packed {
        logic [uart_line_pkg::data_width-1:0] data;
        logic                                 parity_err; // received parity bit did not match
        logic                                 frame_err;  // stop bit was sampled low
    } rx_word_t;

    localparam int fifo_depth = 4;                     // must stay a power of two
    localparam int fifo_addr_width = $clog2(fifo_depth);

    // transmit side walks the frame one bit period per state step
    typedef enum logic [2:0] {
        tx_idle   = 3'd0,
        tx_start  = 3'd1,
        tx_data   = 3'd2,
        tx_parity = 3'd3,
        tx_stop   = 3'd4
    } tx_state_t;

    // receive side, rx_start covers the half period up to the start bit center
    typedef enum logic [2:0] {
        rx_idle   = 3'd0,
        rx_start  = 3'd1,
        rx_data   = 3'd2,
        rx_parity = 3'd3,
        rx_stop   = 3'd4
    } rx_state_t;

endpackage

`default_nettype wire

//--- hdl/uart_tx.sv
`default_nettype none

module uart_tx (
    input  logic                                 clk,
    input  logic                                 rst,
    input  uart_line_pkg::line_cfg_t             cfg,
    input  logic [uart_line_pkg::data_width-1:0] s_data,
    input  logic                                 s_valid,
    output logic                                 s_ready,
    output logic                                 txd,
    output logic                                 busy
);
    import uart_line_pkg::*;
    import uart_stream_pkg::*;

    tx_state_t                 state_q;
    logic [bit_time_width-1:0] cnt_q;       // cycles left in the current bit, minus one
    logic [bit_time_width-1:0] period_last; // reload value for a full bit period
    logic [data_width-1:0]     shift_q;     // bits still to go out, next one at bit 0
    logic [bit_idx_width-1:0]  bit_q;       // index of the data bit now on the line
    logic                      parity_q;    // parity bit built up as data leaves
    logic                      bit_done;

    assign period_last = {cfg.prescale, 3'b000} - bit_time_width'(1);
    assign bit_done = (cnt_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= tx_idle;
            s_ready <= 1'b0;         // rises one cycle after reset is released
            txd     <= 1'b1;         // line idles high
            busy    <= 1'b0;
            cnt_q   <= '0;
            bit_q   <= '0;
        end else begin
            if (!bit_done) begin
                cnt_q <= cnt_q - bit_time_width'(1);
            end

            case (state_q)
                tx_idle: begin
                    s_ready <= 1'b1;
                    if (s_valid && s_ready) begin
                        // the start bit goes out on the edge right after the accept
                        s_ready  <= 1'b0;
                        busy     <= 1'b1;
                        txd      <= 1'b0;
                        cnt_q    <= period_last;
                        shift_q  <= s_data;
                        parity_q <= (cfg.parity == parity_odd); // odd parity starts from one
                        state_q  <= tx_start;
                    end
                end

                tx_start: begin
                    if (bit_done) begin
                        txd      <= shift_q[0];
                        parity_q <= parity_q ^ shift_q[0];
                        shift_q  <= shift_q >> 1;
                        bit_q    <= '0;
                        cnt_q    <= period_last;
                        state_q  <= tx_data;
                    end
                end

                tx_data: begin
                    if (bit_done) begin
                        cnt_q <= period_last;
                        if (bit_q == bit_idx_width'(data_width - 1)) begin
                            // last data bit has held its period
                            if (cfg.parity == parity_none) begin
                                txd     <= 1'b1;
                                state_q <= tx_stop;
                            end else begin
                                txd     <= parity_q; // already folded over all data bits
                                state_q <= tx_parity;
                            end
                        end else begin
                            txd      <= shift_q[0];
                            parity_q <= parity_q ^ shift_q[0];
                            shift_q  <= shift_q >> 1;
                            bit_q    <= bit_q + bit_idx_width'(1);
                        end
                    end
                end

                tx_parity: begin
                    if (bit_done) begin
                        txd     <= 1'b1; // stop bit
                        cnt_q   <= period_last;
                        state_q <= tx_stop;
                    end
                end

                tx_stop: begin
                    // ready comes back only after the stop bit has held its full period
                    if (bit_done) begin
                        busy    <= 1'b0;
                        s_ready <= 1'b1;
                        state_q <= tx_idle;
                    end
                end

                default: state_q <= tx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`default_nettype none

module uart_rx (
    input  logic                       clk,
    input  logic                       rst,
    input  uart_line_pkg::line_cfg_t   cfg,
    input  logic                       rxd,
    output logic                       push,
    output uart_stream_pkg::rx_word_t  push_word
);
    import uart_line_pkg::*;
    import uart_stream_pkg::*;

    logic [1:0]                sync_q;      // two-flop synchronizer on the async line
    logic                      rxd_s;
    rx_state_t                 state_q;
    logic [bit_time_width-1:0] cnt_q;       // cycles to the next sample point, minus one
    logic [bit_time_width-1:0] period_last; // one full bit period
    logic [bit_time_width-1:0] half_last;   // half a bit period, start edge to start center
    logic [data_width-1:0]     shift_q;     // data bits arrive lsb first and shift in at the top
    logic [bit_idx_width-1:0]  bit_q;
    logic                      parity_q;    // expected parity bit so far
    logic                      parity_err_q;
    logic                      wait_high_q; // low stop bit seen, hold off until the line recovers
    logic                      bit_done;

    assign rxd_s = sync_q[1];
    assign period_last = {cfg.prescale, 3'b000} - bit_time_width'(1);
    assign half_last = {1'b0, cfg.prescale, 2'b00} - bit_time_width'(1);
    assign bit_done = (cnt_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= 2'b11; // idle line level, so reset cannot fake a start bit
        end else begin
            sync_q <= {sync_q[0], rxd};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= rx_idle;
            cnt_q       <= '0;
            bit_q       <= '0;
            push        <= 1'b0;
            wait_high_q <= 1'b0;
        end else begin
            push <= 1'b0; // single cycle strobe
            if (!bit_done) begin
                cnt_q <= cnt_q - bit_time_width'(1);
            end

            case (state_q)
                rx_idle: begin
                    if (!rxd_s) begin
                        cnt_q   <= half_last; // next look is at the start bit center
                        state_q <= rx_start;
                    end
                end

                rx_start: begin
                    if (bit_done) begin
                        if (rxd_s) begin
                            state_q <= rx_idle; // line went back high, treat it as a glitch
                        end else begin
                            cnt_q        <= period_last;
                            bit_q        <= '0;
                            parity_q     <= (cfg.parity == parity_odd);
                            parity_err_q <= 1'b0;
                            state_q      <= rx_data;
                        end
                    end
                end

                rx_data: begin
                    if (bit_done) begin
                        shift_q  <= {rxd_s, shift_q[data_width-1:1]};
                        parity_q <= parity_q ^ rxd_s;
                        cnt_q    <= period_last;
                        bit_q    <= bit_q + bit_idx_width'(1);
                        if (bit_q == bit_idx_width'(data_width - 1)) begin
                            state_q <= (cfg.parity == parity_none) ? rx_stop : rx_parity;
                        end
                    end
                end

                rx_parity: begin
                    if (bit_done) begin
                        parity_err_q <= rxd_s ^ parity_q;
                        cnt_q        <= period_last;
                        state_q      <= rx_stop;
                    end
                end

                rx_stop: begin
                    if (wait_high_q) begin
                        if (rxd_s) begin
                            wait_high_q <= 1'b0;
                            state_q     <= rx_idle;
                        end
                    end else if (bit_done) begin
                        // word is handed over in the cycle after the stop sample
                        push                 <= 1'b1;
                        push_word.data       <= shift_q;
                        push_word.parity_err <= parity_err_q;
                        push_word.frame_err  <= ~rxd_s;
                        if (rxd_s) begin
                            state_q <= rx_idle;
                        end else begin
                            wait_high_q <= 1'b1;
                        end
                    end
                end

                default: state_q <= rx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_rx_fifo.sv
`default_nettype none

module uart_rx_fifo (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  uart_stream_pkg::rx_word_t  push_word,
    output uart_stream_pkg::rx_word_t  m_word,
    output logic                       m_valid,
    input  logic                       m_ready,
    output logic                       overrun
);
    import uart_stream_pkg::*;

    rx_word_t mem [fifo_depth];

    // pointers carry one extra wrap bit so full and empty can be told apart
    logic [fifo_addr_width:0] wr_q;
    logic [fifo_addr_width:0] rd_q;
    logic                     empty;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign empty = (wr_q == rd_q);

    // same index, different lap
    assign full = (wr_q[fifo_addr_width] != rd_q[fifo_addr_width])
               && (wr_q[fifo_addr_width-1:0] == rd_q[fifo_addr_width-1:0]);

    assign do_push = push && !full;        // the receiver cannot wait, so a full buffer drops
    assign do_pop  = m_valid && m_ready;

    assign m_valid = !empty;                          // head is valid whenever anything is stored
    assign m_word  = mem[rd_q[fifo_addr_width-1:0]];  // head entry, stable until it is popped

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_q[fifo_addr_width-1:0]] <= push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_q    <= '0;
            rd_q    <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push) begin
                wr_q <= wr_q + 1'b1;
            end
            if (do_pop) begin
                rd_q <= rd_q + 1'b1;
            end
            // sticky until reset, tells software that at least one word was lost
            if (push && full) begin
                overrun <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_link.sv
`default_nettype none

// transmit and receive run on their own, they share only clock, reset and cfg
module uart_link (
    input  logic                                 clk,
    input  logic                                 rst,
    input  uart_line_pkg::line_cfg_t             cfg,

    input  logic [uart_line_pkg::data_width-1:0] s_data,
    input  logic                                 s_valid,
    output logic                                 s_ready,
    output logic                                 txd,
    output logic                                 tx_busy,

    input  logic                                 rxd,
    output uart_stream_pkg::rx_word_t            m_word,
    output logic                                 m_valid,
    input  logic                                 m_ready,
    output logic                                 rx_overrun
);
    import uart_stream_pkg::*;

    logic     push;      // one pulse per received frame
    rx_word_t push_word;

    uart_tx i_tx (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .s_data  (s_data),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .txd     (txd),
        .busy    (tx_busy)
    );

    uart_rx i_rx (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .rxd       (rxd),
        .push      (push),
        .push_word (push_word)
    );

    // buffers words toward the fabric, the only point of rx back-pressure
    uart_rx_fifo i_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_word (push_word),
        .m_word    (m_word),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .overrun   (rx_overrun)
    );

endmodule

`default_nettype wire

//--- test/uart_link_checker.sv
`default_nettype none

module uart_link_checker (
    input logic                                 clk,
    input logic                                 rst,
    input uart_line_pkg::line_cfg_t             cfg,
    input logic [uart_line_pkg::data_width-1:0] s_data,
    input logic                                 s_valid,
    input logic                                 s_ready,
    input logic                                 txd,
    input logic                                 tx_busy,
    input uart_stream_pkg::rx_word_t            m_word,
    input logic                                 m_valid,
    input logic                                 m_ready,
    input logic                                 rx_overrun
);
    import uart_line_pkg::*;

    int fails = 0;                          // failed assertion count

    logic                      timing_q;    // a start bit is being timed
    logic [bit_time_width-1:0] since_q;     // cycles since the accept, minus one
    logic [data_width-1:0]     sent_q;      // byte of the frame under watch
    logic [bit_time_width-1:0] period;

    assign period = {cfg.prescale, 3'b000};

    // starts on the accept, the start bit goes out on that same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            timing_q <= 1'b0;
            since_q  <= '0;
        end else if (s_valid && s_ready) begin
            timing_q <= 1'b1;
            since_q  <= '0;
            sent_q   <= s_data;
        end else if (timing_q) begin
            since_q <= since_q + bit_time_width'(1);
            if (since_q == period) begin
                timing_q <= 1'b0; // data bit 0 has been seen, watch is over
            end
        end
    end

    reset_state: assert property (@(posedge clk)
        rst |=> (txd && !s_ready && !tx_busy && !m_valid && !rx_overrun))
        else begin
            $error("outputs not at their reset values");
            fails++;
        end

    ready_after_reset: assert property (@(posedge clk) $fell(rst) |=> s_ready)
        else begin
            $error("s_ready did not rise in the first cycle after reset");
            fails++;
        end

    ready_busy_excl: assert property (@(posedge clk) disable iff (rst)
        !(s_ready && tx_busy))
        else begin
            $error("s_ready and tx_busy high together");
            fails++;
        end

    // a stalled word has to stay put until the fabric takes it
    word_held: assert property (@(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_word)))
        else begin
            $error("m_word dropped or changed while stalled");
            fails++;
        end

    start_low: assert property (@(posedge clk) disable iff (rst)
        (timing_q && (since_q < period)) |-> !txd)
        else begin
            $error("start bit ended before prescale*8 cycles");
            fails++;
        end

    start_end: assert property (@(posedge clk) disable iff (rst)
        (timing_q && (since_q == period)) |-> (txd == sent_q[0]))
        else begin
            $error("data bit 0 not on txd right after the start bit");
            fails++;
        end

endmodule

bind uart_link uart_link_checker i_checker (.*);

`default_nettype wire

//--- test/uart_link_tb.sv
`default_nettype none

module uart_link_tb;
    import uart_line_pkg::*;
    import uart_stream_pkg::*;

    localparam int wait_limit = 20000;        // negedges any single wait may take

    logic                  clk;
    logic                  rst;
    line_cfg_t             cfg;
    logic [data_width-1:0] s_data;
    logic                  s_valid;
    logic                  s_ready;
    logic                  txd;
    logic                  tx_busy;
    logic                  rxd;
    rx_word_t              m_word;
    logic                  m_valid;
    logic                  m_ready;
    logic                  rx_overrun;

    logic     loopback;                       // rxd follows txd when set and the bit driver otherwise
    logic     drv_line;
    rx_word_t expect_q [$];                   // words the receive stream still owes
    rx_word_t head;
    int       errors;
    int       errs_before;                    // total when the running test began
    int       tests_run;

    assign rxd = loopback ? txd : drv_line;

    uart_link i_dut (.*);

    always #10 clk = ~clk;

    // every accepted word must match the oldest expected one
    always @(posedge clk) begin
        if (!rst && m_valid && m_ready) begin
            assert (expect_q.size() != 0) else begin
                $display("error at %0t: unexpected word %h on m_word", $time, m_word);
                errors++;
            end
            if (expect_q.size() != 0) begin
                head = expect_q.pop_front();
                assert (m_word == head) else begin
                    $display("error at %0t: m_word %h, expected %h", $time, m_word, head);
                    errors++;
                end
            end
        end
    end

    // even parity repeats the xor of the data and odd parity inverts it
    function automatic logic parity_of(input logic [7:0] b, input parity_t p);
        return (p == parity_odd) ? ~^b : ^b;
    endfunction

    function automatic rx_word_t make_word(input logic [7:0] b, input logic pe, input logic fe);
        rx_word_t w;
        w.data       = b;
        w.parity_err = pe;
        w.frame_err  = fe;
        return w;
    endfunction

    function automatic int bit_cycles();
        return int'(cfg.prescale) * 8;
    endfunction

    function automatic int total_errors();
        return errors + i_dut.i_checker.fails;
    endfunction

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic send_byte(input logic [7:0] b);
        int t;
        t = 0;
        @(negedge clk);
        s_data  = b;
        s_valid = 1'b1;
        while (!s_ready) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) give_up("the transmitter to accept a byte");
        end
        @(negedge clk);                       // taken on the rising edge just passed
        s_valid = 1'b0;
    endtask

    // every cycle of every bit must show the value that bit carries
    task automatic check_frame(input logic [7:0] b);
        logic [10:0] bits;                    // start, data lsb first, parity, stop
        int          nbits;
        int          k;
        int          c;
        int          t;
        bits = '0;
        for (k = 0; k < data_width; k++) begin
            bits[k+1] = b[k];
        end
        nbits = 9;
        if (cfg.parity != parity_none) begin
            bits[9] = parity_of(b, cfg.parity);
            nbits   = 10;
        end
        bits[nbits] = 1'b1;
        nbits++;
        t = 0;
        while (txd) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) give_up("a start bit on txd");
        end
        for (k = 0; k < nbits; k++) begin
            for (c = 0; c < bit_cycles(); c++) begin
                assert (txd == bits[k]) else begin
                    $display("error at %0t: txd bit %0d cycle %0d is %b, expected %b",
                             $time, k, c, txd, bits[k]);
                    errors++;
                end
                assert (tx_busy) else begin
                    $display("error at %0t: tx_busy low in bit %0d cycle %0d", $time, k, c);
                    errors++;
                end
                @(negedge clk);
            end
        end
        // the stop bit has just held its full period, so the transmitter is idle again
        assert (s_ready && !tx_busy) else begin
            $display("error at %0t: s_ready %b tx_busy %b after the stop bit, expected 1 and 0",
                     $time, s_ready, tx_busy);
            errors++;
        end
    endtask

    task automatic send_checked(input logic [7:0] b);
        fork
            send_byte(b);
            check_frame(b);
        join
    endtask

    task automatic drive_bit(input logic v);
        repeat (bit_cycles()) begin
            @(negedge clk);
            drv_line = v;
        end
    endtask

    task automatic drive_frame(input logic [7:0] b, input logic par, input logic stop);
        int k;
        drive_bit(1'b0);
        for (k = 0; k < data_width; k++) begin
            drive_bit(b[k]);
        end
        if (cfg.parity != parity_none) begin
            drive_bit(par);
        end
        drive_bit(stop);
        drive_bit(1'b1);                      // idle line lets the receiver recover
        drive_bit(1'b1);
    endtask

    task automatic wait_settled(input string what);
        int t;
        t = 0;
        while (expect_q.size() != 0 || !s_ready) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) give_up(what);
        end
    endtask

    task automatic finish_test(input string name);
        int now;
        now = total_errors();
        tests_run++;
        if (now == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d error(s)", tests_run, name, now - errs_before);
        end
        errs_before = now;
    endtask

    task automatic loopback_run(input parity_t p, input string name);
        logic [7:0] b;
        int         n;
        cfg.parity = p;                       // line is idle here
        for (n = 0; n < 8; n++) begin
            b = 8'($urandom());
            expect_q.push_back(make_word(b, 1'b0, 1'b0));
            send_checked(b);
        end
        wait_settled({name, " words"});
        finish_test(name);
    endtask

    initial begin
        logic [7:0] b;
        int         n;
        int         t;
        void'($urandom(7735));
        clk          = 1'b0;
        rst          = 1'b1;
        cfg.prescale = 16'd2;                 // 16 cycles per bit
        cfg.parity   = parity_none;
        s_data       = '0;
        s_valid      = 1'b0;
        m_ready      = 1'b1;
        loopback     = 1'b1;
        drv_line     = 1'b1;
        errors       = 0;
        errs_before  = 0;
        tests_run    = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        loopback_run(parity_none, "loopback, no parity");
        loopback_run(parity_even, "loopback, even parity");
        loopback_run(parity_odd, "loopback, odd parity");

        // 0x55 flips the line at each data bit boundary, so those edges are timed
        cfg.parity = parity_odd;
        expect_q.push_back(make_word(8'h55, 1'b0, 1'b0));
        send_checked(8'h55);
        wait_settled("the timing frame");
        finish_test("bit timing");

        loopback   = 1'b0;
        cfg.parity = parity_even;
        b = 8'($urandom());
        expect_q.push_back(make_word(b, 1'b1, 1'b0));
        drive_frame(b, ~parity_of(b, parity_even), 1'b1);
        wait_settled("the word with a bad parity bit");
        finish_test("parity error");

        cfg.parity = parity_none;
        b = 8'($urandom());
        expect_q.push_back(make_word(b, 1'b0, 1'b1));
        drive_frame(b, 1'b0, 1'b0);
        wait_settled("the word with a low stop bit");
        finish_test("framing error");

        // fifo keeps the first four and drops the last two frames
        loopback = 1'b1;
        m_ready  = 1'b0;
        for (n = 0; n < 6; n++) begin
            b = 8'($urandom());
            if (n < fifo_depth) begin
                expect_q.push_back(make_word(b, 1'b0, 1'b0));
            end
            send_byte(b);
        end
        t = 0;
        while (!s_ready) begin                // last push lands before the stop bit ends
            @(negedge clk);
            t++;
            if (t > wait_limit) give_up("the sixth frame to leave the transmitter");
        end
        assert (rx_overrun) else begin
            $display("error at %0t: rx_overrun low after six frames", $time);
            errors++;
        end
        m_ready = 1'b1;
        wait_settled("the four buffered words");
        @(negedge clk);
        assert (!m_valid && rx_overrun) else begin
            $display("error at %0t: extra word or overrun cleared after drain", $time);
            errors++;
        end
        finish_test("back-pressure and overrun");

        $display("%0d tests run, %0d errors", tests_run, total_errors());
        if (total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_link.f
hdl/uart_line_pkg.sv
hdl/uart_stream_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_rx_fifo.sv
hdl/uart_link.sv
test/uart_link_checker.sv
test/uart_link_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the uart_link testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module uart_link_tb \
    -f uart_link.f \
    -Mdir obj_dir

# keep running past assertion errors so the summary line is printed
out=$(./obj_dir/Vuart_link_tb +verilator+error+limit+1000 || true)
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
    exit 0
fi
exit 1
